// ==== sim.f ====
hdl/arcade_io_pkg.sv
hdl/control_mapper.sv
hdl/audio_dac.sv
hdl/color_expander.sv
hdl/line_tracker.sv
hdl/scanline_mixer.sv
hdl/arcade_io_top.sv
verification/arcade_io_asserts.sv
verification/arcade_io_tb.sv

// ==== Bender.yml ====
package:
  name: arcade_io

sources:
  # Synthesizable design, package first
  - files:
      - hdl/arcade_io_pkg.sv
      - hdl/control_mapper.sv
      - hdl/audio_dac.sv
      - hdl/color_expander.sv
      - hdl/line_tracker.sv
      - hdl/scanline_mixer.sv
      - hdl/arcade_io_top.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - verification/arcade_io_asserts.sv
      - verification/arcade_io_tb.sv

// ==== verification/arcade_io_tb.sv ====
// Arcade I/O testbench driving random controls, video and audio against a reference model
`timescale 1ns/1ps

module arcade_io_tb import arcade_io_pkg::*; ();

	localparam int N_CTRL = 200;
	localparam int N_VID = 800;
	localparam int N_AUD = 6;
	// Reset, two control phases, five video phases and the audio runs
	localparam int TOTAL_CYCLES = 2 + 2 * N_CTRL + 5 * N_VID + N_AUD * (2 + 1 + 256);

	logic clk_sys, rst, ce_pix, rotate, game_hs, game_vs, audio_bit, vga_hs, vga_vs;
	joy_t kb_joy, joy0, joy1;
	scan_mode_t scan_mode;
	color3_t game_r, game_g;
	color2_t game_b;
	sample_t audio_sample;
	port_t in0_port, in1_port;
	color6_t vga_r, vga_g, vga_b;

	// Model state with cycle count, sync history, line parity and pixels in flight
	int cyc;
	logic prev_hs, prev_vs, model_odd;
	logic [20:0] pipe[$];

	arcade_io_top arcade_io_top_inst (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// Watchdog sized from the phase lengths plus a margin
	initial begin
		#((TOTAL_CYCLES + 100) * 20);
		$display("timeout: the test phases did not finish in the expected time");
		$display("STATUS: FAIL");
		$fatal(1, "watchdog expired");
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("error @ %0t ns: %s got %0h expected %0h", $time, name, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "mismatch");
		end
	endtask

	// Odd-line darkening keeps 3/4, 1/2 or 1/4 of the value
	function automatic color6_t darken(input color6_t v, input logic odd, input scan_mode_t m);
		int x;
		x = v;
		if (odd) begin
			case (m)
				2'd1: x = x - x / 4;
				2'd2: x = x / 2;
				2'd3: x = x / 4;
				default: x = x;
			endcase
		end
		return color6_t'(x);
	endfunction

	// ====================
	// Control port model
	// ====================

	function automatic port_t in0_model(input joy_t kb, input joy_t j0, input joy_t j1,
		input logic rot);
		logic up, dn, lf, rt, tmp;
		port_t p;
		up = kb[KB_UP] | j0[JOY_UP] | j1[JOY_UP];
		dn = kb[KB_DOWN] | j0[JOY_DOWN] | j1[JOY_DOWN];
		lf = kb[KB_LEFT] | j0[JOY_LEFT] | j1[JOY_LEFT];
		rt = kb[KB_RIGHT] | j0[JOY_RIGHT] | j1[JOY_RIGHT];
		// Quarter turn for the rotated cabinet
		if (rot) begin
			tmp = up;
			up = rt;
			rt = dn;
			dn = lf;
			lf = tmp;
		end
		p = 8'hff;
		p[0] = ~up;
		p[1] = ~lf;
		p[2] = ~rt;
		p[3] = ~dn;
		p[5] = ~kb[KB_COIN];
		return p;
	endfunction

	function automatic port_t in1_model(input joy_t kb, input joy_t j0, input joy_t j1);
		port_t p;
		p = 8'hff;
		p[4] = ~(kb[KB_FIRE] | j0[JOY_FIRE] | j1[JOY_FIRE]);
		p[5] = ~kb[KB_START1];
		p[6] = ~kb[KB_START2];
		return p;
	endfunction

	// ====================
	// Video model
	// ====================

	// Runs after each strobe edge, with the inputs that edge sampled still on the pins
	task automatic video_step();
		logic [20:0] old;
		if (game_vs && !prev_vs) begin
			model_odd = 1'b0;
		end else if (game_hs && !prev_hs) begin
			model_odd = ~model_odd;
		end
		prev_hs = game_hs;
		prev_vs = game_vs;
		// Replication is a multiply by 9 for three bits and by 21 for two
		pipe.push_back({game_hs, game_vs, model_odd, color6_t'(game_r * 6'd9),
			color6_t'(game_g * 6'd9), color6_t'(game_b * 6'd21)});
		if (pipe.size() == 2) begin
			old = pipe.pop_front();
			check("vga_hs", vga_hs, old[20]);
			check("vga_vs", vga_vs, old[19]);
			check("vga_r", vga_r, darken(old[17:12], old[18], scan_mode));
			check("vga_g", vga_g, darken(old[11:6], old[18], scan_mode));
			check("vga_b", vga_b, darken(old[5:0], old[18], scan_mode));
		end
	endtask

	// Steps one clock cycle with inputs changing 2 ns after the edge and ce_pix every fourth cycle
	task automatic advance();
		logic strobe;
		logic was_rst;
		strobe = ce_pix;
		was_rst = rst;
		@(posedge clk_sys);
		#2;
		if (strobe && !was_rst) begin
			video_step();
		end
		cyc = cyc + 1;
		ce_pix = (cyc % 4 == 0);
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		repeat (2) advance();
		rst = 1'b0;
		pipe.delete();
		prev_hs = 1'b0;
		prev_vs = 1'b0;
		model_odd = 1'b0;
	endtask

	// ====================
	// Test phases
	// ====================

	task automatic control_phase(input logic rot);
		port_t exp0;
		port_t exp1;
		rotate = rot;
		repeat (N_CTRL) begin
			// Two words ANDed so that fewer controls are pressed at once
			kb_joy = joy_t'($urandom & $urandom);
			joy0 = joy_t'($urandom & $urandom);
			joy1 = joy_t'($urandom & $urandom);
			exp0 = in0_model(kb_joy, joy0, joy1, rot);
			exp1 = in1_model(kb_joy, joy0, joy1);
			advance();
			check("in0_port", in0_port, exp0);
			check("in1_port", in1_port, exp1);
		end
	endtask

	task automatic video_phase(input scan_mode_t mode, input logic with_sync);
		scan_mode = mode;
		repeat (N_VID) begin
			game_r = color3_t'($urandom);
			game_g = color3_t'($urandom);
			game_b = color2_t'($urandom);
			if (with_sync) begin
				game_hs = ($urandom % 6 == 0);
				game_vs = ($urandom % 97 == 0);
			end
			advance();
		end
	endtask

	// Sigma-delta model following the carry every cycle, then the count over 256 cycles
	task automatic audio_phase(input sample_t d);
		int acc;
		int ones;
		audio_sample = d;
		apply_reset();
		ones = 0;
		advance();
		acc = d;
		check("audio_bit", audio_bit, acc >> (ACC_W - 1));
		repeat (256) begin
			advance();
			acc = acc % (1 << (ACC_W - 1)) + d;
			check("audio_bit", audio_bit, acc >> (ACC_W - 1));
			ones = ones + audio_bit;
		end
		check("audio_bit ones vs sample", ones, d);
	endtask

	initial begin
		void'($urandom(32'hcfa7283e));
		{rst, ce_pix, rotate, game_hs, game_vs} = 5'b10000;
		{kb_joy, joy0, joy1, audio_sample} = '0;
		{game_r, game_g, game_b, scan_mode} = '0;
		cyc = 0;
		apply_reset();
		check("in0_port reset", in0_port, 8'hff);
		check("in1_port reset", in1_port, 8'hff);
		check("vga colour reset", {vga_r, vga_g, vga_b, vga_hs, vga_vs}, '0);
		check("audio_bit reset", audio_bit, 1'b0);
		control_phase(1'b0);
		control_phase(1'b1);
		video_phase(2'd0, 1'b0);
		for (int m = 0; m < 4; m++) begin
			video_phase(scan_mode_t'(m), 1'b1);
		end
		repeat (N_AUD) audio_phase(sample_t'($urandom));
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== verification/arcade_io_asserts.sv ====
// Arcade I/O assertions on reset values and strobe-gated VGA output stability
`timescale 1ns/1ps

module arcade_io_asserts import arcade_io_pkg::*; (
	input logic    clk_sys,
	input logic    rst,
	input logic    ce_pix,
	input port_t   in0_port,
	input port_t   in1_port,
	input logic    audio_bit,
	input color6_t vga_r,
	input color6_t vga_g,
	input color6_t vga_b,
	input logic    vga_hs,
	input logic    vga_vs
);

	// Idle controls read all ones once reset has been seen
	a_ports_idle: assert property (@(posedge clk_sys)
		rst |=> (in0_port == 8'hff && in1_port == 8'hff))
		else $error("input ports not idle after reset");

	a_audio_low: assert property (@(posedge clk_sys) rst |=> !audio_bit)
		else $error("audio_bit not low after reset");

	// The video registers only load on a pixel strobe
	a_vga_hold: assert property (@(posedge clk_sys) disable iff (rst)
		!ce_pix |=> $stable({vga_r, vga_g, vga_b, vga_hs, vga_vs}))
		else $error("VGA outputs changed without a pixel strobe");

endmodule

bind arcade_io_top arcade_io_asserts arcade_io_asserts_inst (.*);

// ==== hdl/arcade_io_top.sv ====
// Arcade I/O top level joining control mapping, audio conversion and the video path
`timescale 1ns/1ps

module arcade_io_top import arcade_io_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst,
	input  logic       ce_pix,
	input  logic       rotate,
	input  logic       game_hs,
	input  logic       game_vs,
	input  joy_t       kb_joy,
	input  joy_t       joy0,
	input  joy_t       joy1,
	input  scan_mode_t scan_mode,
	input  color3_t    game_r,
	input  color3_t    game_g,
	input  color2_t    game_b,
	input  sample_t    audio_sample,
	output port_t      in0_port,
	output port_t      in1_port,
	output color6_t    vga_r,
	output color6_t    vga_g,
	output color6_t    vga_b,
	output logic       vga_hs,
	output logic       vga_vs,
	output logic       audio_bit
);

	// ====================
	// Controls and audio
	// ====================

	control_mapper control_mapper_inst (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.kb_joy   (kb_joy),
		.joy0     (joy0),
		.joy1     (joy1),
		.rotate   (rotate),
		.in0_port (in0_port),
		.in1_port (in1_port)
	);

	audio_dac audio_dac_inst (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.audio_sample (audio_sample),
		.audio_bit    (audio_bit)
	);

	// ====================
	// Video path
	// ====================

	// First stage outputs, colour and sync stay aligned strobe for strobe
	color6_t exp_r;
	color6_t exp_g;
	color6_t exp_b;
	logic    odd_line;
	logic    line_hs;
	logic    line_vs;

	color_expander color_expander_inst (
		.clk_sys (clk_sys),
		.rst     (rst),
		.ce_pix  (ce_pix),
		.game_r  (game_r),
		.game_g  (game_g),
		.game_b  (game_b),
		.exp_r   (exp_r),
		.exp_g   (exp_g),
		.exp_b   (exp_b)
	);

	line_tracker line_tracker_inst (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.ce_pix   (ce_pix),
		.game_hs  (game_hs),
		.game_vs  (game_vs),
		.odd_line (odd_line),
		.line_hs  (line_hs),
		.line_vs  (line_vs)
	);

	// Second stage, two strobes from game pins to VGA pins
	scanline_mixer scanline_mixer_inst (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.ce_pix    (ce_pix),
		.odd_line  (odd_line),
		.line_hs   (line_hs),
		.line_vs   (line_vs),
		.scan_mode (scan_mode),
		.exp_r     (exp_r),
		.exp_g     (exp_g),
		.exp_b     (exp_b),
		.vga_r     (vga_r),
		.vga_g     (vga_g),
		.vga_b     (vga_b),
		.vga_hs    (vga_hs),
		.vga_vs    (vga_vs)
	);

endmodule

// ==== hdl/scanline_mixer.sv ====
// Scanline mixer that darkens odd lines and registers the final VGA pixel and sync
`timescale 1ns/1ps

module scanline_mixer import arcade_io_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst,
	input  logic       ce_pix,
	input  logic       odd_line,
	input  logic       line_hs,
	input  logic       line_vs,
	input  scan_mode_t scan_mode,
	input  color6_t    exp_r,
	input  color6_t    exp_g,
	input  color6_t    exp_b,
	output color6_t    vga_r,
	output color6_t    vga_g,
	output color6_t    vga_b,
	output logic       vga_hs,
	output logic       vga_vs
);

	// Darkening rule for one component on an odd line
	// Mode 1 keeps three quarters, mode 2 half, mode 3 a quarter
	function automatic color6_t dim(input color6_t val, input scan_mode_t mode);
		color6_t res;
		case (mode)
			2'd1:    res = val - (val >> 2);
			2'd2:    res = val >> 1;
			2'd3:    res = val >> 2;
			default: res = val;
		endcase
		return res;
	endfunction

	// ====================
	// Output registers
	// ====================

	// Even lines pass straight through, mode 0 is handled inside dim
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else if (ce_pix) begin
			vga_hs <= line_hs;
			vga_vs <= line_vs;
			vga_r  <= odd_line ? dim(exp_r, scan_mode) : exp_r;
			vga_g  <= odd_line ? dim(exp_g, scan_mode) : exp_g;
			vga_b  <= odd_line ? dim(exp_b, scan_mode) : exp_b;
		end
	end

endmodule

// ==== hdl/line_tracker.sv ====
// Line tracker that flags odd lines from sync edges and aligns sync with the colour path
`timescale 1ns/1ps

module line_tracker (
	input  logic clk_sys,
	input  logic rst,
	input  logic ce_pix,
	input  logic game_hs,
	input  logic game_vs,
	output logic odd_line,
	output logic line_hs,
	output logic line_vs
);

	// The registered sync doubles as the previous value for edge detection
	logic hs_rise;
	logic vs_rise;

	assign hs_rise = game_hs & ~line_hs;
	assign vs_rise = game_vs & ~line_vs;

	// ====================
	// Sync and parity
	// ====================

	// Everything moves on the pixel strobe only
	// Vertical sync wins over horizontal, so each frame starts on an even line
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			line_hs  <= 1'b0;
			line_vs  <= 1'b0;
			odd_line <= 1'b0;
		end else if (ce_pix) begin
			line_hs <= game_hs;
			line_vs <= game_vs;
			if (vs_rise) begin
				odd_line <= 1'b0;
			end else if (hs_rise) begin
				// New line, flip the parity
				odd_line <= ~odd_line;
			end
		end
	end

endmodule

// ==== hdl/color_expander.sv ====
// Colour expander that widens 3-3-2 game colour to 6-6-6 on each pixel strobe
`timescale 1ns/1ps

module color_expander import arcade_io_pkg::*; (
	input  logic    clk_sys,
	input  logic    rst,
	input  logic    ce_pix,
	input  color3_t game_r,
	input  color3_t game_g,
	input  color2_t game_b,
	output color6_t exp_r,
	output color6_t exp_g,
	output color6_t exp_b
);

	// Repeating the bits keeps zero at zero and full scale at full scale
	// A 3-bit value fills six bits in two copies, a 2-bit value in three
	color6_t wide_r;
	color6_t wide_g;
	color6_t wide_b;

	assign wide_r = {2{game_r}};
	assign wide_g = {2{game_g}};
	assign wide_b = {3{game_b}};

	// Sampled only on the pixel strobe, held in between
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			exp_r <= '0;
			exp_g <= '0;
			exp_b <= '0;
		end else if (ce_pix) begin
			exp_r <= wide_r;
			exp_g <= wide_g;
			exp_b <= wide_b;
		end
	end

endmodule

// ==== hdl/audio_dac.sv ====
// Audio converter that turns an 8-bit sample into a first-order sigma-delta bit stream
`timescale 1ns/1ps

module audio_dac import arcade_io_pkg::*; (
	input  logic    clk_sys,
	input  logic    rst,
	input  sample_t audio_sample,
	output logic    audio_bit
);

	// Accumulator with the carry held in its top bit
	logic [ACC_W-1:0] acc;

	// Each cycle the sample is added to the low part and the old carry dropped
	// The carry rate then equals sample / 256, so over 256 cycles the low bits
	// come back to where they started and exactly sample carries were produced
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			acc <= '0;
		end else begin
			acc <= {1'b0, acc[ACC_W-2:0]} + {1'b0, audio_sample};
		end
	end

	// The carry register is the output bit, so the stream is glitch free
	assign audio_bit = acc[ACC_W-1];

endmodule

// ==== hdl/control_mapper.sv ====
// Control mapper that merges keyboard and joysticks into active-low game input ports
`timescale 1ns/1ps

module control_mapper import arcade_io_pkg::*; (
	input  logic  clk_sys,
	input  logic  rst,
	input  joy_t  kb_joy,
	input  joy_t  joy0,
	input  joy_t  joy1,
	input  logic  rotate,
	output port_t in0_port,
	output port_t in1_port
);

	// ====================
	// Merged directions
	// ====================

	// Any source pressing a direction counts, keyboard or either stick
	logic src_up;
	logic src_down;
	logic src_left;
	logic src_right;
	logic src_fire;

	assign src_up    = kb_joy[KB_UP]    | joy0[JOY_UP]    | joy1[JOY_UP];
	assign src_down  = kb_joy[KB_DOWN]  | joy0[JOY_DOWN]  | joy1[JOY_DOWN];
	assign src_left  = kb_joy[KB_LEFT]  | joy0[JOY_LEFT]  | joy1[JOY_LEFT];
	assign src_right = kb_joy[KB_RIGHT] | joy0[JOY_RIGHT] | joy1[JOY_RIGHT];
	assign src_fire  = kb_joy[KB_FIRE]  | joy0[JOY_FIRE]  | joy1[JOY_FIRE];

	// A rotated cabinet turns the stick a quarter turn
	// Up comes from right, right from down, down from left, left from up
	logic m_up;
	logic m_down;
	logic m_left;
	logic m_right;

	assign m_up    = rotate ? src_right : src_up;
	assign m_right = rotate ? src_down  : src_right;
	assign m_down  = rotate ? src_left  : src_down;
	assign m_left  = rotate ? src_up    : src_left;

	// ====================
	// Port registers
	// ====================

	// Game ports are active low, so the unused zero bits read back as ones
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			// Nothing pressed
			in0_port <= '1;
			in1_port <= '1;
		end else begin
			in0_port <= ~{2'b00, kb_joy[KB_COIN], 1'b0, m_down, m_right, m_left, m_up};
			in1_port <= ~{1'b0, kb_joy[KB_START2], kb_joy[KB_START1], src_fire, 4'b0000};
		end
	end

endmodule

// ==== hdl/arcade_io_pkg.sv ====
// Arcade I/O package with shared widths, vector types and control bit positions
package arcade_io_pkg;

	// Component widths of the game colour bus and the VGA bus
	localparam int COLOR3_W = 3;
	localparam int COLOR2_W = 2;
	localparam int COLOR6_W = 6;

	// Widths of the control bytes, the audio sample and the scanline setting
	localparam int BYTE_W = 8;
	localparam int SCAN_W = 2;

	// Width of the sigma-delta accumulator, one carry bit above the sample
	localparam int ACC_W = 9;

	// Bit positions in a joystick byte, one bit per control, active high
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE  = 4;

	// Bit positions in the keyboard joystick byte
	localparam int KB_FIRE   = 0;
	localparam int KB_START1 = 1;
	localparam int KB_START2 = 2;
	localparam int KB_COIN   = 3;
	localparam int KB_RIGHT  = 4;
	localparam int KB_LEFT   = 5;
	localparam int KB_UP     = 6;
	localparam int KB_DOWN   = 7;

	typedef logic [COLOR3_W-1:0] color3_t;
	typedef logic [COLOR2_W-1:0] color2_t;
	typedef logic [COLOR6_W-1:0] color6_t;
	typedef logic [BYTE_W-1:0]   joy_t;
	typedef logic [BYTE_W-1:0]   port_t;
	typedef logic [BYTE_W-1:0]   sample_t;
	// 0 is off, 1 is 25 %, 2 is 50 % and 3 is 75 % darkening
	typedef logic [SCAN_W-1:0]   scan_mode_t;

endpackage
